//--- verilog/afp_eng_pkg.sv
/*
  Shared constants of the load/store engine.
  The walked window is limited to address bits 31..7, so touch pages stop at 1G.
*/
`default_nettype none

package afp_eng_pkg;

  // Sequencer state ---
  localparam int state_w       = 5;   // One-hot bits
  localparam int st_idle       = 0;   // Waiting for enable
  localparam int st_actag      = 1;   // Tag assignment running
  localparam int st_send       = 2;   // Loads and stores flowing
  localparam int st_err_intrpt = 3;   // Error interrupt pending
  localparam int st_stop       = 4;   // Draining outstanding tags

  // Address fields ---
  localparam int offset_lo = 7;    // 128 B granule
  localparam int offset_hi = 31;   // Top of walk window
  localparam int page_lo   = 12;   // 4 K page number
  localparam int ea_lo     = 6;    // Command address LSB

  // Page-size codes as log2 of the size
  localparam int pg_code_w = 6;
  localparam logic [pg_code_w-1:0] pg_4k  = 6'd12;
  localparam logic [pg_code_w-1:0] pg_64k = 6'd16;
  localparam logic [pg_code_w-1:0] pg_2m  = 6'd21;
  localparam logic [pg_code_w-1:0] pg_16m = 6'd24;
  localparam logic [pg_code_w-1:0] pg_1g  = 6'd30;

  // Misc
  localparam logic [1:0] size_256 = 2'b11;   // 256 B command size
  localparam int         pasid_w  = 10;

endpackage

`default_nettype wire

//--- verilog/eng_main_seq.sv
/*
  One-hot main sequencer of the load/store engine.
  Config levels are registered here, so each change acts one cycle late.
  cfg_send_interrupt is a one-cycle pulse, held until the interrupt is issued.
  A state vector that is not one-hot forces idle and flags main_seq_error.
*/
`default_nettype none
`timescale 1ns/100ps

module eng_main_seq
(
  input  wire                               clock,
  input  wire                               reset,
  input  wire                               cfg_enable,
  input  wire                               cfg_use_pasid_for_actag,
  input  wire                               cfg_send_interrupt,
  input  wire                               cfg_error_intrpt_enable,
  input  wire                               actag_seq_done,
  input  wire                               arb_tags_idle,
  input  wire                               intrpt_idle,
  input  wire                               xtouch_error,
  input  wire                               cpy_ld_error,
  input  wire                               cpy_st_error,
  output logic [afp_eng_pkg::state_w-1:0]   main_state,
  output logic                              main_seq_error,
  output logic                              main_seq_done,
  output logic                              start_capture,
  output logic                              start_actag_seq,
  output logic                              start_cpy_ld_seq,
  output logic                              start_cpy_st_seq,
  output logic                              start_intrpt_seq,
  output logic                              cmd_is_intrpt,
  output logic                              eng_arb_init
);

  localparam logic [afp_eng_pkg::state_w-1:0] idle_vec = 1 << afp_eng_pkg::st_idle;

  logic                            enable_q;
  logic                            use_pasid_q;
  logic                            err_intrpt_en_q;
  logic                            send_interrupt_q;   // Host pulse, held
  logic                            cmd_is_intrpt_q;
  logic [afp_eng_pkg::state_w-1:0] main_seq_q;
  logic [afp_eng_pkg::state_w-1:0] seq_next;
  logic                            bad_onehot;
  logic                            any_error;
  logic                            all_idle;
  logic                            host_intrpt;
  logic                            start_intrpt;

  // Zero or more than one bit set
  assign bad_onehot = (main_seq_q == '0) || ((main_seq_q & (main_seq_q - 1'b1)) != '0);

  assign any_error   = xtouch_error | cpy_ld_error | cpy_st_error;
  assign all_idle    = arb_tags_idle & intrpt_idle;
  assign host_intrpt = main_seq_q[afp_eng_pkg::st_send] & send_interrupt_q & intrpt_idle;
  assign start_intrpt = host_intrpt | (main_seq_q[afp_eng_pkg::st_err_intrpt] & intrpt_idle);

  // Next state --------------------
  always_comb
  begin
    seq_next        = '0;
    start_capture   = 1'b0;
    start_actag_seq = 1'b0;
    case (1'b1)
      main_seq_q[afp_eng_pkg::st_idle]:
      begin
        if (enable_q && !any_error)
        begin
          start_capture   = 1'b1;           // Address gen loads the base
          start_actag_seq = !use_pasid_q;   // Tag step only when not skipped
          if (use_pasid_q)
            seq_next[afp_eng_pkg::st_send] = 1'b1;
          else
            seq_next[afp_eng_pkg::st_actag] = 1'b1;
        end
        else
          seq_next[afp_eng_pkg::st_idle] = 1'b1;
      end
      main_seq_q[afp_eng_pkg::st_actag]:
      begin
        if (!actag_seq_done)
          seq_next[afp_eng_pkg::st_actag] = 1'b1;
        else if (enable_q)
          seq_next[afp_eng_pkg::st_send] = 1'b1;
        else
          seq_next[afp_eng_pkg::st_idle] = 1'b1;   // Disabled while tagging
      end
      main_seq_q[afp_eng_pkg::st_send]:
      begin
        if (!enable_q)
          seq_next[afp_eng_pkg::st_stop] = 1'b1;
        else if (any_error && err_intrpt_en_q)
          seq_next[afp_eng_pkg::st_err_intrpt] = 1'b1;
        else if (any_error)
          seq_next[afp_eng_pkg::st_stop] = 1'b1;
        else
          seq_next[afp_eng_pkg::st_send] = 1'b1;
      end
      main_seq_q[afp_eng_pkg::st_err_intrpt]:
      begin
        if (!enable_q || start_intrpt)   // Interrupt gone out, or abandoned
          seq_next[afp_eng_pkg::st_stop] = 1'b1;
        else
          seq_next[afp_eng_pkg::st_err_intrpt] = 1'b1;
      end
      main_seq_q[afp_eng_pkg::st_stop]:
      begin
        if (all_idle)
          seq_next[afp_eng_pkg::st_idle] = 1'b1;
        else
          seq_next[afp_eng_pkg::st_stop] = 1'b1;   // Wait for tags to drain
      end
      default:
        seq_next = idle_vec;
    endcase
  end

  // Registers --------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      main_seq_q       <= idle_vec;
      enable_q         <= 1'b0;
      use_pasid_q      <= 1'b0;
      err_intrpt_en_q  <= 1'b0;
      send_interrupt_q <= 1'b0;
      cmd_is_intrpt_q  <= 1'b0;
    end
    else
    begin
      main_seq_q       <= bad_onehot ? idle_vec : seq_next;
      enable_q         <= cfg_enable;
      use_pasid_q      <= cfg_use_pasid_for_actag;
      err_intrpt_en_q  <= cfg_error_intrpt_enable;
      send_interrupt_q <= cfg_send_interrupt | (send_interrupt_q & ~host_intrpt);
      if (start_intrpt)
        cmd_is_intrpt_q <= host_intrpt;   // 0 marks an error interrupt
    end
  end

  assign main_state       = main_seq_q;
  assign main_seq_error   = bad_onehot;
  assign main_seq_done    = main_seq_q[afp_eng_pkg::st_idle];
  assign start_cpy_ld_seq = main_seq_q[afp_eng_pkg::st_send];   // Level for whole phase
  assign start_cpy_st_seq = main_seq_q[afp_eng_pkg::st_send];
  assign start_intrpt_seq = start_intrpt;
  assign cmd_is_intrpt    = cmd_is_intrpt_q;
  assign eng_arb_init     = start_capture;                      // Arbiter restarts with the walk

endmodule

`default_nettype wire

//--- verilog/eng_addr_gen.sv
/*
  Effective address walk of the load/store engine.
  Config is sampled on every idle cycle, so it must be stable before enable.
  The walk wraps inside bits 31..12 selected by the offset mask.
*/
`default_nettype none
`timescale 1ns/100ps

module eng_addr_gen #(
  parameter int ea_width = 64
)
(
  input  wire                                                   clock,
  input  wire                                                   reset,
  input  wire  [afp_eng_pkg::state_w-1:0]                       main_state,
  input  wire                                                   start_capture,
  input  wire  [ea_width-1:afp_eng_pkg::page_lo]                cfg_base_addr,
  input  wire  [afp_eng_pkg::offset_hi:afp_eng_pkg::page_lo]    cfg_offset_mask,
  input  wire  [1:0]                                            cfg_ld_size,
  input  wire  [1:0]                                            cfg_st_size,
  input  wire  [afp_eng_pkg::pasid_w-1:0]                       cfg_pasid,
  input  wire                                                   arb_ld_gnt,
  input  wire                                                   arb_st_gnt,
  output logic [ea_width-1:afp_eng_pkg::ea_lo]                  cpy_ea,
  output logic [afp_eng_pkg::pasid_w-1:0]                       cmd_pasid,
  output logic [afp_eng_pkg::offset_hi:afp_eng_pkg::offset_lo]  offset_addr,
  output logic [ea_width-1:afp_eng_pkg::page_lo]                base_addr,
  output logic [afp_eng_pkg::offset_hi:afp_eng_pkg::page_lo]    offset_mask,
  output logic                                                  addr_step
);

  localparam int hi = afp_eng_pkg::offset_hi;
  localparam int lo = afp_eng_pkg::offset_lo;
  localparam int pg = afp_eng_pkg::page_lo;

  logic          step_256_q;   // Any 256 B size selected
  logic [hi:lo]  walk_sum;
  logic [hi:lo]  next_addr;

  assign addr_step = arb_ld_gnt | arb_st_gnt;   // One step per grant

  // Step by 256 B keeps bit 7 clear
  assign walk_sum = step_256_q ? {offset_addr[hi:lo+1] + 1'b1, 1'b0}
                               : offset_addr + 1'b1;

  // Masked bits follow the walk, the rest stay on the base
  assign next_addr[hi:pg]   = (base_addr[hi:pg] & ~offset_mask) | (walk_sum[hi:pg] & offset_mask);
  assign next_addr[pg-1:lo] = walk_sum[pg-1:lo];

  // --------------------
  always_ff @(posedge clock)
  begin
    if (main_state[afp_eng_pkg::st_idle])
    begin
      base_addr   <= cfg_base_addr;
      offset_mask <= cfg_offset_mask;
      cmd_pasid   <= cfg_pasid;
      step_256_q  <= (cfg_ld_size == afp_eng_pkg::size_256) ||
                     (cfg_st_size == afp_eng_pkg::size_256);
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      offset_addr <= '0;
    else if (start_capture)
      offset_addr <= {base_addr[hi:pg], {(pg - lo){1'b0}}};   // Page aligned start
    else if (addr_step)
      offset_addr <= next_addr;
  end

  // Upper bits come straight from the base, bit 6 always clear
  assign cpy_ea = {base_addr[ea_width-1:hi+1], offset_addr, 1'b0};

endmodule

`default_nettype wire

//--- verilog/eng_xtouch.sv
/*
  Translation touch on page crossings.
  Page sizes from 4 K to 1 G only; 1 G with N=4 and unknown codes touch 4 K, N=1.
  The touch address wraps through the same offset mask as the walk.
*/
`default_nettype none
`timescale 1ns/100ps

module eng_xtouch #(
  parameter int ea_width = 64
)
(
  input  wire                                                   clock,
  input  wire                                                   reset,
  input  wire  [afp_eng_pkg::state_w-1:0]                       main_state,
  input  wire                                                   cfg_xtouch_enable,
  input  wire  [1:0]                                            cfg_xtouch_pg_n,
  input  wire  [afp_eng_pkg::pg_code_w-1:0]                     cfg_xtouch_pg_size,
  input  wire  [afp_eng_pkg::offset_hi:afp_eng_pkg::offset_lo]  offset_addr,
  input  wire  [ea_width-1:afp_eng_pkg::page_lo]                base_addr,
  input  wire  [afp_eng_pkg::offset_hi:afp_eng_pkg::page_lo]    offset_mask,
  input  wire                                                   addr_step,
  output logic                                                  start_xtouch_seq,
  output logic [ea_width-1:0]                                   xtouch_ea
);

  localparam int hi   = afp_eng_pkg::offset_hi;
  localparam int lo   = afp_eng_pkg::offset_lo;
  localparam int pg   = afp_eng_pkg::page_lo;
  localparam int pn_w = hi - pg + 1;   // Page number width

  logic                              en_q;
  logic                              step_q;      // Address moved last edge
  logic [1:0]                        pg_n_q;
  logic [afp_eng_pkg::pg_code_w-1:0] pg_size_q;
  logic [4:0]                        pg_shift;    // log2(size / 4K)
  logic                              adder_fallback;
  logic [2:0]                        pg_count;
  logic [4:0]                        adder_shift;
  logic [hi:lo]                      pg_mask;     // Offset bits inside one page
  logic [hi:pg]                      xtouch_adder;
  logic [hi:pg]                      plus_n;
  logic [hi:pg]                      xtouch_addr_q;
  logic                              crossed_page;

  // Page size decode --------------------
  always_comb
  begin
    adder_fallback = 1'b0;
    case (pg_size_q)
      afp_eng_pkg::pg_4k:  pg_shift = 5'd0;
      afp_eng_pkg::pg_64k: pg_shift = 5'd4;
      afp_eng_pkg::pg_2m:  pg_shift = 5'd9;
      afp_eng_pkg::pg_16m: pg_shift = 5'd12;
      afp_eng_pkg::pg_1g:
      begin
        pg_shift       = 5'd18;
        adder_fallback = (pg_n_q == 2'd3);   // 4 G ahead leaves the window
      end
      default:
      begin
        pg_shift       = 5'd0;
        adder_fallback = 1'b1;
      end
    endcase
  end

  assign pg_mask = ({{(pn_w + pg - lo - 1){1'b0}}, 1'b1} << (pg_shift + (pg - lo))) - 1'b1;

  // Landed on a boundary when no in-page offset bit is set
  assign crossed_page     = step_q & ~|(offset_addr & pg_mask);
  assign start_xtouch_seq = crossed_page & en_q & main_state[afp_eng_pkg::st_send];

  // Touch N+1 pages ahead of the current one
  assign pg_count     = adder_fallback ? 3'd1 : {1'b0, pg_n_q} + 3'd1;
  assign adder_shift  = adder_fallback ? 5'd0 : pg_shift;
  assign xtouch_adder = {{(pn_w - 3){1'b0}}, pg_count} << adder_shift;
  assign plus_n       = offset_addr[hi:pg] + xtouch_adder;

  // --------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      en_q   <= 1'b0;
      step_q <= 1'b0;
    end
    else
    begin
      en_q   <= cfg_xtouch_enable;
      step_q <= addr_step;
    end
    pg_n_q    <= cfg_xtouch_pg_n;
    pg_size_q <= cfg_xtouch_pg_size;
    if (start_xtouch_seq)
      xtouch_addr_q <= (base_addr[hi:pg] & ~offset_mask) | (plus_n & offset_mask);
  end

  assign xtouch_ea = {base_addr[ea_width-1:hi+1], xtouch_addr_q, {pg{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/afp_eng_top.sv
/*
  Load/store traffic engine, main sequencer with address and touch logic.
  ea_width must exceed 32; bits above 31 come from the base address only.
*/
`default_nettype none
`timescale 1ns/100ps

module afp_eng_top #(
  parameter int ea_width = 64
)
(
  input  wire                                                  clock,
  input  wire                                                  reset,
  input  wire                                                  cfg_enable,
  input  wire                                                  cfg_use_pasid_for_actag,
  input  wire  [ea_width-1:afp_eng_pkg::page_lo]               cfg_base_addr,
  input  wire  [afp_eng_pkg::offset_hi:afp_eng_pkg::page_lo]   cfg_offset_mask,
  input  wire  [1:0]                                           cfg_ld_size,
  input  wire  [1:0]                                           cfg_st_size,
  input  wire  [afp_eng_pkg::pasid_w-1:0]                      cfg_pasid,
  input  wire                                                  cfg_send_interrupt,
  input  wire                                                  cfg_error_intrpt_enable,
  input  wire                                                  cfg_xtouch_enable,
  input  wire  [1:0]                                           cfg_xtouch_pg_n,
  input  wire  [afp_eng_pkg::pg_code_w-1:0]                    cfg_xtouch_pg_size,
  input  wire                                                  actag_seq_done,
  input  wire                                                  arb_tags_idle,
  input  wire                                                  arb_ld_gnt,
  input  wire                                                  arb_st_gnt,
  input  wire                                                  xtouch_error,
  input  wire                                                  cpy_ld_error,
  input  wire                                                  cpy_st_error,
  input  wire                                                  intrpt_idle,
  output logic [afp_eng_pkg::state_w-1:0]                      main_state,
  output logic                                                 main_seq_error,
  output logic                                                 main_seq_done,
  output logic                                                 start_actag_seq,
  output logic                                                 start_cpy_ld_seq,
  output logic                                                 start_cpy_st_seq,
  output logic                                                 start_xtouch_seq,
  output logic                                                 start_intrpt_seq,
  output logic                                                 cmd_is_intrpt,
  output logic                                                 eng_arb_init,
  output logic [ea_width-1:afp_eng_pkg::ea_lo]                 cpy_ea,
  output logic [ea_width-1:0]                                  xtouch_ea,
  output logic [afp_eng_pkg::pasid_w-1:0]                      cmd_pasid
);

  logic                                                 start_capture;
  logic [afp_eng_pkg::offset_hi:afp_eng_pkg::offset_lo] offset_addr;   // Current walk position
  logic [ea_width-1:afp_eng_pkg::page_lo]               base_addr;
  logic [afp_eng_pkg::offset_hi:afp_eng_pkg::page_lo]   offset_mask;
  logic                                                 addr_step;

  eng_main_seq u_main_seq (
    .clock, .reset, .cfg_enable, .cfg_use_pasid_for_actag, .cfg_send_interrupt,
    .cfg_error_intrpt_enable, .actag_seq_done, .arb_tags_idle, .intrpt_idle,
    .xtouch_error, .cpy_ld_error, .cpy_st_error, .main_state, .main_seq_error,
    .main_seq_done, .start_capture, .start_actag_seq, .start_cpy_ld_seq,
    .start_cpy_st_seq, .start_intrpt_seq, .cmd_is_intrpt, .eng_arb_init
  );

  eng_addr_gen #(.ea_width(ea_width)) u_addr_gen (
    .clock, .reset, .main_state, .start_capture, .cfg_base_addr, .cfg_offset_mask,
    .cfg_ld_size, .cfg_st_size, .cfg_pasid, .arb_ld_gnt, .arb_st_gnt, .cpy_ea,
    .cmd_pasid, .offset_addr, .base_addr, .offset_mask, .addr_step
  );

  // Touch runs off the walk one cycle behind
  eng_xtouch #(.ea_width(ea_width)) u_xtouch (
    .clock, .reset, .main_state, .cfg_xtouch_enable, .cfg_xtouch_pg_n,
    .cfg_xtouch_pg_size, .offset_addr, .base_addr, .offset_mask, .addr_step,
    .start_xtouch_seq, .xtouch_ea
  );

endmodule

`default_nettype wire

//--- verif/tb_afp_eng_tests.svh
/*
  Test tasks and model helpers of the engine testbench.
  All tasks start and end 10 ns after a rising edge.
*/
`ifndef TB_AFP_ENG_TESTS_SVH
`define TB_AFP_ENG_TESTS_SVH

// Model rules --------------------
function automatic logic [31:0] step_bytes();
  return (cfg_ld_size == 2'b11 || cfg_st_size == 2'b11) ? 32'd256 : 32'd128;
endfunction

// Masked bits 31..12 follow the sum, the rest stay on the base
function automatic logic [31:0] merge_base(input logic [31:0] sum);
  logic [31:0] m;
  m = {cfg_offset_mask, 12'h000};
  return ({cfg_base_addr[31:12], 12'h000} & ~m) | (sum & (m | 32'hfff));
endfunction

function automatic logic [31:0] page_bytes();
  case (cfg_xtouch_pg_size)
    6'd12, 6'd16, 6'd21, 6'd24, 6'd30: return 32'd1 << cfg_xtouch_pg_size;
    default: return 32'h1000;   // Unknown sizes act as 4 K
  endcase
endfunction

function automatic logic [31:0] touch_addr(input logic [31:0] a);
  logic [31:0] add;
  logic        fallback;
  fallback = (page_bytes() == 32'h1000 && cfg_xtouch_pg_size != 6'd12) ||
             (cfg_xtouch_pg_size == 6'd30 && cfg_xtouch_pg_n == 2'd3);
  add = fallback ? 32'h1000 : (cfg_xtouch_pg_n + 32'd1) * page_bytes();
  return merge_base(a + add) & 32'hffff_f000;
endfunction

// Helpers --------------------
task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
  assert (got === exp)
  else
  begin
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    errors++;
  end
endtask

task automatic tick();
  @(posedge clock);
  #10;
endtask

task automatic init_inputs();
  cfg_enable = 1'b0;
  cfg_use_pasid_for_actag = 1'b0;
  cfg_base_addr = '0;
  cfg_offset_mask = '0;
  cfg_ld_size = 2'b00;
  cfg_st_size = 2'b00;
  cfg_pasid = 10'h2a5;
  cfg_send_interrupt = 1'b0;
  cfg_error_intrpt_enable = 1'b0;
  cfg_xtouch_enable = 1'b0;
  cfg_xtouch_pg_n = 2'd0;
  cfg_xtouch_pg_size = 6'd12;
  actag_seq_done = 1'b0;
  arb_tags_idle = 1'b1;
  arb_ld_gnt = 1'b0;
  arb_st_gnt = 1'b0;
  xtouch_error = 1'b0;
  cpy_ld_error = 1'b0;
  cpy_st_error = 1'b0;
  intrpt_idle = 1'b1;
endtask

// Sampled at the falling edge, then back to the drive point
task automatic wait_state(input int idx, input string name);
  int i;
  for (i = 0; i < timeout; i++)
  begin
    @(negedge clock);
    if (main_state[idx])
      break;
  end
  if (!main_state[idx])
  begin
    $display("Timed out waiting for state %s", name);
    errors++;
  end
  tick();
endtask

task automatic wait_intrpt();
  int i;
  for (i = 0; i < timeout; i++)
  begin
    @(negedge clock);
    if (start_intrpt_seq)
      break;
  end
  if (!start_intrpt_seq)
  begin
    $display("Timed out waiting for start_intrpt_seq");
    errors++;
  end
  tick();   // cmd_is_intrpt valid from here
endtask

task automatic finish_test(input string name, input int err0);
  tests_run++;
  if (errors == err0)
    $display("PASS  %s", name);
  else
  begin
    $display("FAIL  %s (%0d errors)", name, errors - err0);
    tests_failed++;
  end
endtask

// Tests --------------------
task automatic test_reset();
  int e0;
  e0 = errors;
  @(negedge clock);
  check_val("main_state", main_state, 5'b00001);
  check_val("start_actag_seq", start_actag_seq, 0);
  check_val("start_xtouch_seq", start_xtouch_seq, 0);
  check_val("start_intrpt_seq", start_intrpt_seq, 0);
  check_val("eng_arb_init", eng_arb_init, 0);
  tick();
  finish_test("reset", e0);
endtask

task automatic test_walk(input logic pasid, input logic [1:0] ld_sz, input logic [1:0] st_sz,
                         input logic [5:0] pg_sz, input logic [1:0] pg_n,
                         input logic [31:12] mask, input logic [63:12] base, input int grants);
  int          e0;
  int          a0;
  int          c0;
  int          n;
  int          r;
  logic [31:0] rnd;
  e0 = errors;
  rnd = $urandom;
  cfg_pasid = rnd[9:0];              // Fresh PASID per run
  cfg_use_pasid_for_actag = pasid;   // Config settles while idle
  cfg_ld_size = ld_sz;
  cfg_st_size = st_sz;
  cfg_xtouch_pg_size = pg_sz;
  cfg_xtouch_pg_n = pg_n;
  cfg_xtouch_enable = 1'b1;
  cfg_offset_mask = mask;
  cfg_base_addr = base;
  repeat (2) tick();
  a0 = actag_count;
  c0 = arb_init_count;
  cfg_enable = 1'b1;
  if (!pasid)
  begin
    wait_state(1, "actag");
    repeat ($urandom % 5) tick();
    check_val("main_state", main_state, 5'b00010);   // Held until tags done
    actag_seq_done = 1'b1;
    tick();
    actag_seq_done = 1'b0;
  end
  wait_state(2, "send");
  check_val("start_actag_seq pulses", actag_count - a0, pasid ? 0 : 1);
  check_val("eng_arb_init pulses", arb_init_count - c0, 1);
  check_val("cmd_pasid", cmd_pasid, rnd[9:0]);
  cfg_pasid = ~rnd[9:0];   // Not sampled outside idle
  tick();
  check_val("cmd_pasid", cmd_pasid, rnd[9:0]);
  finish_test(pasid ? "start-up direct" : "start-up via actag", e0);
  e0 = errors;
  walk_phase = 1'b1;
  n = 0;
  while (n < grants)
  begin
    r = $urandom % 4;
    arb_ld_gnt = (r == 0);
    arb_st_gnt = (r == 1);
    if (r < 2)
      n++;
    tick();
  end
  arb_ld_gnt = 1'b0;
  arb_st_gnt = 1'b0;
  repeat (3) tick();   // Let the last touch land
  walk_phase = 1'b0;
  cfg_enable = 1'b0;
  wait_state(0, "idle");
  finish_test("address walk and touch", e0);
endtask

task automatic test_errors();
  int e0;
  e0 = errors;
  cfg_use_pasid_for_actag = 1'b1;
  cfg_error_intrpt_enable = 1'b1;
  intrpt_idle = 1'b0;
  arb_tags_idle = 1'b0;
  tick();
  cfg_enable = 1'b1;
  wait_state(2, "send");
  repeat ($urandom % 8) tick();
  cpy_ld_error = 1'b1;
  tick();
  cpy_ld_error = 1'b0;
  check_val("main_state", main_state, 5'b01000);   // err_intrpt
  repeat (3) tick();
  check_val("start_intrpt_seq", start_intrpt_seq, 0);
  intrpt_idle = 1'b1;
  wait_intrpt();
  check_val("cmd_is_intrpt", cmd_is_intrpt, 0);
  check_val("main_state", main_state, 5'b10000);
  cfg_enable = 1'b0;
  tick();
  arb_tags_idle = 1'b1;
  wait_state(0, "idle");
  // Error interrupt off goes straight to stop
  cfg_error_intrpt_enable = 1'b0;
  arb_tags_idle = 1'b0;
  repeat (2) tick();
  cfg_enable = 1'b1;
  wait_state(2, "send");
  repeat ($urandom % 8) tick();
  xtouch_error = 1'b1;
  tick();
  xtouch_error = 1'b0;
  check_val("main_state", main_state, 5'b10000);
  cfg_enable = 1'b0;
  repeat (2) tick();
  arb_tags_idle = 1'b1;
  wait_state(0, "idle");
  finish_test("errors", e0);
endtask

task automatic test_host_intrpt();
  int e0;
  e0 = errors;
  intrpt_idle = 1'b0;
  cfg_enable = 1'b1;
  wait_state(2, "send");
  cfg_send_interrupt = 1'b1;   // One-cycle pulse
  tick();
  cfg_send_interrupt = 1'b0;
  repeat (4)
  begin
    check_val("start_intrpt_seq", start_intrpt_seq, 0);
    tick();
  end
  intrpt_idle = 1'b1;
  wait_intrpt();
  check_val("cmd_is_intrpt", cmd_is_intrpt, 1);
  check_val("main_state", main_state, 5'b00100);
  finish_test("host interrupt", e0);
endtask

task automatic test_shutdown();
  int e0;
  e0 = errors;
  arb_tags_idle = 1'b0;
  intrpt_idle = 1'b0;
  cfg_enable = 1'b0;
  wait_state(4, "stop");
  repeat (3) tick();
  check_val("main_state", main_state, 5'b10000);
  arb_tags_idle = 1'b1;
  repeat (3) tick();
  check_val("main_state", main_state, 5'b10000);   // Interrupt engine still busy
  intrpt_idle = 1'b1;
  wait_state(0, "idle");
  finish_test("shutdown", e0);
endtask

`endif

//--- verif/tb_afp_eng.sv
/*
  Testbench of the load/store engine with a reference model of address and touch.
  Inputs change 10 ns after the rising edge; outputs are checked at the falling edge.
  Walk checks are only active while the test is granting in the send state.
*/
`default_nettype none
`timescale 1ns/100ps

module tb_afp_eng;

  localparam int ea_width = 64;
  localparam int timeout  = 200;   // Cycles per wait

  logic                  clock;
  logic                  reset;
  logic                  cfg_enable;
  logic                  cfg_use_pasid_for_actag;
  logic [ea_width-1:12]  cfg_base_addr;
  logic [31:12]          cfg_offset_mask;
  logic [1:0]            cfg_ld_size;
  logic [1:0]            cfg_st_size;
  logic [9:0]            cfg_pasid;
  logic                  cfg_send_interrupt;
  logic                  cfg_error_intrpt_enable;
  logic                  cfg_xtouch_enable;
  logic [1:0]            cfg_xtouch_pg_n;
  logic [5:0]            cfg_xtouch_pg_size;
  logic                  actag_seq_done;
  logic                  arb_tags_idle;
  logic                  arb_ld_gnt;
  logic                  arb_st_gnt;
  logic                  xtouch_error;
  logic                  cpy_ld_error;
  logic                  cpy_st_error;
  logic                  intrpt_idle;
  logic [4:0]            main_state;
  logic                  main_seq_error;
  logic                  main_seq_done;
  logic                  start_actag_seq;
  logic                  start_cpy_ld_seq;
  logic                  start_cpy_st_seq;
  logic                  start_xtouch_seq;
  logic                  start_intrpt_seq;
  logic                  cmd_is_intrpt;
  logic                  eng_arb_init;
  logic [ea_width-1:6]   cpy_ea;
  logic [ea_width-1:0]   xtouch_ea;
  logic [9:0]            cmd_pasid;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          arb_init_count;   // eng_arb_init pulses seen
  int          actag_count;      // start_actag_seq pulses seen
  logic        walk_phase;       // Grants flowing, model checks on
  logic        pend_x;           // Touch pulse expected this cycle
  logic        have_x;           // exp_xea is valid
  logic [31:0] exp_addr;         // Model byte address, bits 31..0
  logic [31:0] pend_xea;
  logic [31:0] exp_xea;

  afp_eng_top #(.ea_width(ea_width)) i_dut (.*);

  // Clock --------------------
  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Reference model --------------------
  always @(posedge clock)
  begin : model
    logic [31:0] nxt;
    if (reset)
    begin
      pend_x         <= 1'b0;
      have_x         <= 1'b0;
      arb_init_count <= 0;
      actag_count    <= 0;
    end
    else
    begin
      if (start_actag_seq)
        actag_count <= actag_count + 1;
      if (eng_arb_init)
      begin
        exp_addr       <= {cfg_base_addr[31:12], 12'h000};   // Walk starts page aligned
        arb_init_count <= arb_init_count + 1;
        pend_x         <= 1'b0;
        have_x         <= 1'b0;
      end
      else
      begin
        if (walk_phase && (arb_ld_gnt || arb_st_gnt))
        begin
          nxt      = merge_base(exp_addr + step_bytes());
          exp_addr <= nxt;
          pend_x   <= cfg_xtouch_enable && ((nxt & (page_bytes() - 1)) == 0);
          pend_xea <= touch_addr(nxt);
        end
        else
          pend_x <= 1'b0;
        if (pend_x)
        begin
          exp_xea <= pend_xea;
          have_x  <= 1'b1;
        end
      end
    end
  end

  // Checks at the falling edge --------------------
  always @(negedge clock)
  begin
    if (!reset)
    begin
      check_val("main_seq_error", main_seq_error, 0);
      check_val("main_seq_done", main_seq_done, main_state[0]);
      check_val("start_cpy_ld_seq", start_cpy_ld_seq, main_state[2]);   // Level in send
      check_val("start_cpy_st_seq", start_cpy_st_seq, main_state[2]);
      assert (!start_intrpt_seq || intrpt_idle)
      else
      begin
        $display("Interrupt started while the interrupt engine was busy");
        errors++;
      end
      if (walk_phase)
      begin
        check_val("cpy_ea", {cpy_ea, 6'b0}, {cfg_base_addr[63:32], exp_addr});
        check_val("start_xtouch_seq", start_xtouch_seq, pend_x);
        if (have_x)
          check_val("xtouch_ea", xtouch_ea, {cfg_base_addr[63:32], exp_xea});
      end
    end
  end

  `include "tb_afp_eng_tests.svh"

  // Main sequence --------------------
  initial
  begin
    void'($urandom(32'h02fd4cf6));
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    walk_phase = 1'b0;
    init_inputs();
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #10 reset = 1'b0;
    test_reset();
    test_walk(1'b0, 2'b11, 2'b00, 6'd12, 2'd1, 20'h00003, 52'h1234_5678_9abc_d, 120);
    test_walk(1'b1, 2'b01, 2'b01, 6'd16, 2'd2, 20'h000ff, 52'h0fed_cba9_8765_e, 200);
    test_errors();
    test_host_intrpt();
    test_shutdown();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
verilog/afp_eng_pkg.sv
verilog/eng_main_seq.sv
verilog/eng_addr_gen.sv
verilog/eng_xtouch.sv
verilog/afp_eng_top.sv
verif/tb_afp_eng.sv

//--- Bender.yml
package:
  name: afp_eng

sources:
  - files:
      - verilog/afp_eng_pkg.sv
      - verilog/eng_main_seq.sv
      - verilog/eng_addr_gen.sv
      - verilog/eng_xtouch.sv
      - verilog/afp_eng_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_afp_eng.sv
